/* hdl/rx_tx_pkg.sv */
// shared rx port types; crc is reflected ieee 802.3 with residue taken before the final inversion
package rx_tx_pkg;

    localparam logic [7:0]  PREAMBLE_BYTE  = 8'h55;
    localparam logic [7:0]  SFD_BYTE       = 8'hD5;
    localparam logic [31:0] CRC32_CONSTANT = 32'hDEBB20E3; // good-frame residue, fcs included
    localparam logic [31:0] CRC32_POLY     = 32'hEDB88320; // 0x04C11DB7 bit reversed
    localparam logic [31:0] CRC32_INIT     = 32'hFFFFFFFF;

    // one byte of lsb-first crc, eight shift steps unrolled by the loop
    function automatic logic [31:0] crc32_next(
        input logic [7:0]  data,
        input logic [31:0] crc
    );
        logic [31:0] c;
        c = crc ^ {24'h0, data};
        for (int i = 0; i < 8; i++) begin
            c = c[0] ? ((c >> 1) ^ CRC32_POLY) : (c >> 1);
        end
        return c;
    endfunction

    typedef enum logic [1:0] {
        IDLE,     // waiting for the first preamble byte
        PREAMBLE, // remaining preamble bytes and the sfd
        HEADER,   // dst, src and ethertype
        PAYLOAD   // data and fcs up to the last byte
    } rx_state_t;

    typedef enum logic [1:0] {
        HOLD,
        CLEAR,
        INC
    } ctr_op_t;

    // one fifo entry
    typedef struct packed {
        logic [7:0] data;
        logic       last; // final byte before rx_dv fell
        logic       err;  // rx_er was high with this byte
    } gmii_word_t;

    // one beat towards switch memory
    typedef struct packed {
        logic [7:0] data;
        logic       sof;
        logic       eof;
        logic       error; // only meaningful with eof
    } frame_beat_t;

    typedef struct packed {
        logic [47:0] dst;
        logic [47:0] src;
    } mac_hdr_t;

    // single-cycle strobes into the statistics block
    typedef struct packed {
        logic frame_done;
        logic crc_err;
        logic rx_err;
        logic preamble_err;
    } stat_evt_t;

endpackage

/* hdl/cdc_byte_fifo.sv */
// gmii to switch_clk fifo; depth is 2**FIFO_ADDR_W, needs FIFO_ADDR_W >= 2, overflow is not handled
`timescale 1ns/1ps

module cdc_byte_fifo
    import rx_tx_pkg::*;
#(
    parameter int FIFO_ADDR_W = 6
) (
    input  logic       gmii_rx_clk,
    input  logic [7:0] gmii_rx_data,
    input  logic       gmii_rx_dv,
    input  logic       gmii_rx_er,
    input  logic       switch_clk,
    input  logic       switch_rst_n,
    input  logic       rd_en,
    output gmii_word_t fifo_word,
    output logic       empty
);
    localparam int DEPTH = 2 ** FIFO_ADDR_W;

    logic [1:0]           wr_rst_sync;
    logic                 wr_rst_n;     // switch reset, released on gmii_rx_clk
    logic                 hold_vld;     // lookahead register holds a byte
    logic [7:0]           hold_data;
    logic                 hold_err;
    gmii_word_t           push_word;
    logic                 push, full, wr_inc, rd_inc;
    logic [FIFO_ADDR_W:0] wr_bin, wr_bin_nxt, wr_gray;
    logic [FIFO_ADDR_W:0] rd_bin, rd_bin_nxt, rd_gray;
    logic [FIFO_ADDR_W:0] rd_gray_w1, rd_gray_w2; // read pointer seen by the write side
    logic [FIFO_ADDR_W:0] wr_gray_r1, wr_gray_r2; // write pointer seen by the read side
    gmii_word_t           mem [DEPTH];

    // asserts immediately, releases two gmii edges later
    always_ff @(posedge gmii_rx_clk or negedge switch_rst_n) begin
        if (!switch_rst_n) begin
            wr_rst_sync <= 2'b00;
        end else begin
            wr_rst_sync <= {wr_rst_sync[0], 1'b1};
        end
    end
    assign wr_rst_n = wr_rst_sync[1];

    // one byte of lookahead so the byte before the dv falling edge gets last
    always_ff @(posedge gmii_rx_clk or negedge wr_rst_n) begin
        if (!wr_rst_n) begin
            hold_vld <= 1'b0;
        end else begin
            hold_vld <= gmii_rx_dv;
        end
    end

    always_ff @(posedge gmii_rx_clk) begin
        if (gmii_rx_dv) begin
            hold_data <= gmii_rx_data;
            hold_err  <= gmii_rx_er;
        end
    end

    assign push      = hold_vld; // every held byte leaves next cycle, either way
    assign push_word = '{data: hold_data, last: !gmii_rx_dv, err: hold_err};

    assign full   = (wr_gray == {~rd_gray_w2[FIFO_ADDR_W:FIFO_ADDR_W-1],
                                 rd_gray_w2[FIFO_ADDR_W-2:0]});
    assign wr_inc = push && !full;
    assign wr_bin_nxt = wr_bin + {{FIFO_ADDR_W{1'b0}}, wr_inc};

    always_ff @(posedge gmii_rx_clk or negedge wr_rst_n) begin
        if (!wr_rst_n) begin
            wr_bin     <= '0;
            wr_gray    <= '0;
            rd_gray_w1 <= '0;
            rd_gray_w2 <= '0;
        end else begin
            wr_bin     <= wr_bin_nxt;
            wr_gray    <= wr_bin_nxt ^ (wr_bin_nxt >> 1);
            rd_gray_w1 <= rd_gray;
            rd_gray_w2 <= rd_gray_w1;
        end
    end

    always_ff @(posedge gmii_rx_clk) begin
        if (wr_inc) begin
            mem[wr_bin[FIFO_ADDR_W-1:0]] <= push_word;
        end
    end

    // read side, switch_clk
    assign empty      = (rd_gray == wr_gray_r2);
    assign rd_inc     = rd_en && !empty;
    assign rd_bin_nxt = rd_bin + {{FIFO_ADDR_W{1'b0}}, rd_inc};

    always_ff @(posedge switch_clk or negedge switch_rst_n) begin
        if (!switch_rst_n) begin
            rd_bin     <= '0;
            rd_gray    <= '0;
            wr_gray_r1 <= '0;
            wr_gray_r2 <= '0;
        end else begin
            rd_bin     <= rd_bin_nxt;
            rd_gray    <= rd_bin_nxt ^ (rd_bin_nxt >> 1);
            wr_gray_r1 <= wr_gray;
            wr_gray_r2 <= wr_gray_r1;
        end
    end

    // registered output, word valid the cycle after rd_en and held until the next read
    always_ff @(posedge switch_clk) begin
        if (rd_inc) begin
            fifo_word <= mem[rd_bin[FIFO_ADDR_W-1:0]];
        end
    end

    a_no_overflow: assert property (@(posedge gmii_rx_clk) disable iff (!wr_rst_n)
        push |-> !full);

    a_no_underflow: assert property (@(posedge switch_clk) disable iff (!switch_rst_n)
        rd_en |-> !empty);

endmodule

/* hdl/rx_frame_fsm.sv */
// frame parser; expects seven 0x55 then 0xD5, no length or ethertype checks, beats held while grant low
`timescale 1ns/1ps

module rx_frame_fsm
    import rx_tx_pkg::*;
(
    input  logic        switch_clk,
    input  logic        switch_rst_n,
    input  gmii_word_t  fifo_word,
    input  logic        empty,
    input  logic [4:0]  pos,
    input  logic        frame_grant,
    output logic        rd_en,
    output ctr_op_t     ctr_op,
    output logic        byte_strobe,
    output frame_beat_t frame_beat,
    output logic        frame_valid,
    output stat_evt_t   stat_evt
);
    rx_state_t   state_q, state_d;
    logic        word_vld;        // fifo_word holds a byte not consumed yet
    logic        drop_q, drop_d;  // discarding the rest of a rejected frame
    logic        err_q;           // sticky rx_er over the frame
    logic [31:0] crc_q, crc_d;
    logic        crc_bad_q;       // residue mismatch of the beat sitting in frame_beat
    logic        in_data, out_ready, consume;
    logic        load_beat, pre_err, eof_xfer;
    logic        beat_crc_bad;

    assign in_data   = (state_q == HEADER) || (state_q == PAYLOAD);
    // preamble bytes wait for a pending eof beat to leave, keeps stat events apart
    assign out_ready = in_data ? (!frame_valid || frame_grant) : !frame_valid;
    assign consume   = word_vld && out_ready;
    assign rd_en     = !empty && (!word_vld || consume) && (!in_data || frame_grant);

    assign crc_d        = crc32_next(fifo_word.data, crc_q);
    assign beat_crc_bad = (crc_d != CRC32_CONSTANT); // only looked at on the last byte
    assign eof_xfer     = frame_valid && frame_grant && frame_beat.eof;

    always_comb begin
        state_d     = state_q;
        drop_d      = drop_q;
        ctr_op      = HOLD;
        byte_strobe = 1'b0;
        load_beat   = 1'b0;
        pre_err     = 1'b0;
        case (state_q)
            IDLE: begin
                ctr_op = CLEAR; // pos starts from 0 at the first preamble byte
                if (consume) begin
                    if (drop_q) begin
                        drop_d = !fifo_word.last;
                    end else if (fifo_word.data == PREAMBLE_BYTE && !fifo_word.last) begin
                        ctr_op  = INC;
                        state_d = PREAMBLE;
                    end else begin
                        pre_err = 1'b1;
                        drop_d  = !fifo_word.last;
                    end
                end
            end
            PREAMBLE: begin
                if (consume) begin
                    ctr_op = INC;
                    if (fifo_word.last ||
                        fifo_word.data != ((pos == 5'd7) ? SFD_BYTE : PREAMBLE_BYTE)) begin
                        pre_err = 1'b1;
                        drop_d  = !fifo_word.last; // skip to end of this frame
                        state_d = IDLE;
                    end else if (pos == 5'd7) begin
                        state_d = HEADER; // sfd seen
                    end
                end
            end
            HEADER: begin
                if (consume) begin
                    ctr_op      = INC;
                    byte_strobe = 1'b1;
                    load_beat   = 1'b1;
                    if (fifo_word.last) begin
                        state_d = IDLE; // runt, still closed with eof
                    end else if (pos == 5'd21) begin
                        state_d = PAYLOAD; // ethertype done
                    end
                end
            end
            PAYLOAD: begin
                if (consume) begin
                    load_beat = 1'b1;
                    if (fifo_word.last) begin
                        state_d = IDLE;
                    end
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge switch_clk or negedge switch_rst_n) begin
        if (!switch_rst_n) begin
            state_q     <= IDLE;
            word_vld    <= 1'b0;
            drop_q      <= 1'b0;
            err_q       <= 1'b0;
            crc_q       <= CRC32_INIT;
            crc_bad_q   <= 1'b0;
            frame_valid <= 1'b0;
            stat_evt    <= '0;
        end else begin
            state_q  <= state_d;
            drop_q   <= drop_d;
            word_vld <= rd_en || (word_vld && !consume);
            if (state_q == IDLE) begin
                err_q <= 1'b0;
            end else if (consume) begin
                err_q <= err_q || fifo_word.err; // preamble bytes count too
            end
            if (!in_data) begin
                crc_q <= CRC32_INIT;
            end else if (consume) begin
                crc_q <= crc_d;
            end
            if (load_beat) begin
                frame_valid <= 1'b1;
                crc_bad_q   <= fifo_word.last && beat_crc_bad;
            end else if (frame_grant) begin
                frame_valid <= 1'b0;
            end
            stat_evt.frame_done   <= eof_xfer;
            stat_evt.crc_err      <= eof_xfer && crc_bad_q;
            stat_evt.rx_err       <= (eof_xfer && frame_beat.error) || pre_err;
            stat_evt.preamble_err <= pre_err;
        end
    end

    // beat payload
    always_ff @(posedge switch_clk) begin
        if (load_beat) begin
            frame_beat.data  <= fifo_word.data;
            frame_beat.sof   <= (state_q == HEADER) && (pos == 5'd8); // first dst byte
            frame_beat.eof   <= fifo_word.last;
            frame_beat.error <= fifo_word.last && (beat_crc_bad || err_q || fifo_word.err);
        end
    end

    a_beat_held: assert property (@(posedge switch_clk) disable iff (!switch_rst_n)
        frame_valid && !frame_grant |=> frame_valid && $stable(frame_beat));

endmodule

/* hdl/frame_byte_counter.sv */
// byte position within preamble and header, saturates at 31 so payload length is not tracked
`timescale 1ns/1ps

module frame_byte_counter
    import rx_tx_pkg::*;
(
    input  logic       switch_clk,
    input  logic       switch_rst_n,
    input  ctr_op_t    ctr_op,
    output logic [4:0] pos
);
    logic at_max;

    assign at_max = (pos == 5'd31);

    always_ff @(posedge switch_clk or negedge switch_rst_n) begin
        if (!switch_rst_n) begin
            pos <= 5'd0;
        end else begin
            case (ctr_op)
                CLEAR: pos <= 5'd0;
                INC: begin
                    if (!at_max) begin
                        pos <= pos + 5'd1; // stick at 31 past the header
                    end
                end
                default: pos <= pos; // HOLD
            endcase
        end
    end

endmodule

/* hdl/mac_header_capture.sv */
// dst at byte positions 8-13, src at 14-19; addresses keep their last value between frames
`timescale 1ns/1ps

module mac_header_capture
    import rx_tx_pkg::*;
(
    input  logic       switch_clk,
    input  logic       switch_rst_n,
    input  logic       byte_strobe,
    input  logic [7:0] data,
    input  logic [4:0] pos,
    output mac_hdr_t   mac_hdr,
    output logic       hdr_valid
);
    logic in_dst, in_src;

    assign in_dst = byte_strobe && (pos >= 5'd8) && (pos <= 5'd13);
    assign in_src = byte_strobe && (pos >= 5'd14) && (pos <= 5'd19);

    // first byte on the wire ends up in the top octet
    always_ff @(posedge switch_clk) begin
        if (in_dst) begin
            mac_hdr.dst <= {mac_hdr.dst[39:0], data};
        end
        if (in_src) begin
            mac_hdr.src <= {mac_hdr.src[39:0], data};
        end
    end

    always_ff @(posedge switch_clk or negedge switch_rst_n) begin
        if (!switch_rst_n) begin
            hdr_valid <= 1'b0;
        end else begin
            hdr_valid <= byte_strobe && (pos == 5'd19); // last src byte just shifted in
        end
    end

endmodule

/* hdl/rx_stats_regs.sv */
// wishbone classic stats slave; reads 0-3 return counters, any write clears all, write data ignored
`timescale 1ns/1ps

module rx_stats_regs
    import rx_tx_pkg::*;
#(
    parameter int WB_ADDR_W = 4
) (
    input  logic                 switch_clk,
    input  logic                 switch_rst_n,
    input  stat_evt_t            stat_evt,
    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_we,
    input  logic [WB_ADDR_W-1:0] wb_adr,
    input  logic [31:0]          wb_dat_w,
    output logic [31:0]          wb_dat_r,
    output logic                 wb_ack
);
    logic [31:0] cnt [4];  // 0 frames, 1 crc, 2 rx err, 3 preamble
    logic [3:0]  evt_vec;
    logic        req;      // new cycle, not yet acked
    logic        wr_clr;
    logic [31:0] rd_val;

    assign req     = wb_cyc && wb_stb && !wb_ack;
    assign wr_clr  = req && wb_we; // any address, any data
    assign evt_vec = {stat_evt.preamble_err, stat_evt.rx_err,
                      stat_evt.crc_err, stat_evt.frame_done};

    always_ff @(posedge switch_clk or negedge switch_rst_n) begin
        if (!switch_rst_n) begin
            for (int i = 0; i < 4; i++) begin
                cnt[i] <= 32'd0;
            end
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (wr_clr) begin
                    cnt[i] <= 32'd0; // clear wins over a same-cycle event
                end else if (evt_vec[i]) begin
                    cnt[i] <= cnt[i] + 32'd1;
                end
            end
        end
    end

    // unmapped addresses read zero
    always_comb begin
        rd_val = 32'd0;
        if (int'(wb_adr) < 4) begin
            rd_val = cnt[wb_adr[1:0]];
        end
    end

    always_ff @(posedge switch_clk or negedge switch_rst_n) begin
        if (!switch_rst_n) begin
            wb_ack   <= 1'b0;
            wb_dat_r <= 32'd0;
        end else begin
            wb_ack <= req; // one cycle after cyc and stb, single pulse
            if (req && !wb_we) begin
                wb_dat_r <= rd_val;
            end
        end
    end

    a_ack_pulse: assert property (@(posedge switch_clk) disable iff (!switch_rst_n)
        wb_ack |=> !wb_ack);

endmodule

/* hdl/rx_mac_control.sv */
// receive side of one switch port; gmii in, byte stream with valid/grant out, stats on wishbone
`timescale 1ns/1ps

module rx_mac_control
    import rx_tx_pkg::*;
#(
    parameter int FIFO_ADDR_W = 6,
    parameter int WB_ADDR_W   = 4
) (
    input  logic                 gmii_rx_clk,
    input  logic [7:0]           gmii_rx_data,
    input  logic                 gmii_rx_dv,
    input  logic                 gmii_rx_er,
    input  logic                 switch_clk,
    input  logic                 switch_rst_n,
    output frame_beat_t          frame_beat,
    output logic                 frame_valid,
    input  logic                 frame_grant,
    output mac_hdr_t             mac_hdr,
    output logic                 hdr_valid,
    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_we,
    input  logic [WB_ADDR_W-1:0] wb_adr,
    input  logic [31:0]          wb_dat_w,
    output logic [31:0]          wb_dat_r,
    output logic                 wb_ack
);
    gmii_word_t fifo_word;
    logic       empty, rd_en, byte_strobe;
    ctr_op_t    ctr_op;
    logic [4:0] pos;
    stat_evt_t  stat_evt;

    cdc_byte_fifo #(.FIFO_ADDR_W(FIFO_ADDR_W)) cdc_byte_fifo_i (
        .gmii_rx_clk, .gmii_rx_data, .gmii_rx_dv, .gmii_rx_er,
        .switch_clk, .switch_rst_n, .rd_en, .fifo_word, .empty
    );

    rx_frame_fsm rx_frame_fsm_i (
        .switch_clk, .switch_rst_n, .fifo_word, .empty, .pos, .frame_grant,
        .rd_en, .ctr_op, .byte_strobe, .frame_beat, .frame_valid, .stat_evt
    );

    frame_byte_counter frame_byte_counter_i (.switch_clk, .switch_rst_n, .ctr_op, .pos);

    mac_header_capture mac_header_capture_i (
        .switch_clk, .switch_rst_n, .byte_strobe,
        .data(fifo_word.data), // byte being consumed this cycle
        .pos, .mac_hdr, .hdr_valid
    );

    rx_stats_regs #(.WB_ADDR_W(WB_ADDR_W)) rx_stats_regs_i (
        .switch_clk, .switch_rst_n, .stat_evt,
        .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack
    );

endmodule

/* dv/tb_clk_gen.sv */
// free-running clock from time 0; rst_n is low for RST_CYCLES rising edges, then released on an edge
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter real PERIOD_NS  = 10.0,
    parameter int  RST_CYCLES = 2
) (
    output logic clk,
    output logic rst_n
);
    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1; // released on an edge, like any other registered input
    end

    always #(PERIOD_NS / 2.0) clk = ~clk;

endmodule

/* dv/rx_mac_control_tb.sv */
// rx port test with 46-100 byte payloads; dut fifo set to 128 entries, above the longest frame
`timescale 1ns/1ps

module rx_mac_control_tb
    import rx_tx_pkg::*;
();
    localparam int WAIT_LIMIT = 5000; // switch cycles allowed per wait loop
    localparam int ACK_LIMIT  = 20;
    localparam int BATCH      = 12;

    logic        gmii_rx_clk;
    logic        switch_clk, switch_rst_n;
    logic [7:0]  gmii_rx_data;
    logic        gmii_rx_dv, gmii_rx_er;
    logic        frame_grant = 1'b0;
    frame_beat_t frame_beat;
    logic        frame_valid;
    mac_hdr_t    mac_hdr;
    logic        hdr_valid;
    logic        wb_cyc, wb_stb, wb_we;
    logic [3:0]  wb_adr;
    logic [31:0] wb_dat_w, wb_dat_r;
    logic        wb_ack;

    frame_beat_t exp_beats [$];
    mac_hdr_t    exp_hdrs [$];
    logic [31:0] exp_cnt [4];   // frames, crc errors, rx errors, preamble errors
    int          beat_errs = 0;
    int          hdr_errs  = 0;
    int          stat_errs = 0;
    int          timeouts  = 0;

    tb_clk_gen #(.PERIOD_NS(8.0), .RST_CYCLES(2)) gmii_clk_gen_i (
        .clk(gmii_rx_clk), .rst_n()
    );
    tb_clk_gen #(.PERIOD_NS(10.0), .RST_CYCLES(2)) switch_clk_gen_i (
        .clk(switch_clk), .rst_n(switch_rst_n)
    );

    rx_mac_control #(.FIFO_ADDR_W(7), .WB_ADDR_W(4)) rx_mac_control_i (.*);

    always @(posedge switch_clk) begin
        frame_grant <= (($urandom() % 4) != 0); // high three cycles in four
    end

    // reflected crc-32, one bit per step, result inverted as sent on the wire
    function automatic logic [31:0] fcs_of(input logic [7:0] bytes [$]);
        logic [31:0] crc;
        logic        fb;
        crc = 32'hFFFFFFFF;
        foreach (bytes[i]) begin
            for (int b = 0; b < 8; b++) begin
                fb  = crc[0] ^ bytes[i][b]; // lsb of each byte goes first
                crc = crc >> 1;
                if (fb) begin
                    crc = crc ^ 32'hEDB88320;
                end
            end
        end
        return ~crc;
    endfunction

    task automatic check_beat(input frame_beat_t got, input frame_beat_t want);
        if (got !== want) begin
            beat_errs++;
            $display("ERR %0t beat got %02h sof/eof/error %b%b%b, expected %02h %b%b%b",
                     $time, got.data, got.sof, got.eof, got.error,
                     want.data, want.sof, want.eof, want.error);
        end
    endtask

    task automatic check_hdr(input mac_hdr_t got, input mac_hdr_t want);
        if (got !== want) begin
            hdr_errs++;
            $display("ERR %0t header got dst %012h src %012h, expected dst %012h src %012h",
                     $time, got.dst, got.src, want.dst, want.src);
        end
    endtask

    task automatic check_stat(input logic [31:0] got, input logic [31:0] want, input int adr);
        if (got !== want) begin
            stat_errs++;
            $display("ERR %0t stat address %0d got %0d, expected %0d", $time, adr, got, want);
        end
    endtask

    // output side, sampled on the edge where the beat or header is taken
    always @(posedge switch_clk) begin : out_monitor
        frame_beat_t want_beat;
        mac_hdr_t    want_hdr;
        if (switch_rst_n && frame_valid && frame_grant) begin
            if (exp_beats.size() == 0) begin
                beat_errs++;
                $display("a beat came out at %0t while no frame was outstanding", $time);
            end else begin
                want_beat = exp_beats.pop_front();
                check_beat(frame_beat, want_beat);
            end
        end
        if (switch_rst_n && hdr_valid) begin
            if (exp_hdrs.size() == 0) begin
                hdr_errs++;
                $display("hdr_valid pulsed at %0t while no header was expected", $time);
            end else begin
                want_hdr = exp_hdrs.pop_front();
                check_hdr(mac_hdr, want_hdr);
            end
        end
    end

    task automatic wait_drained();
        for (int t = 0; t < WAIT_LIMIT; t++) begin
            if (exp_beats.size() == 0 && exp_hdrs.size() == 0) begin
                break;
            end
            @(posedge switch_clk);
        end
        if (exp_beats.size() != 0 || exp_hdrs.size() != 0) begin
            timeouts++;
            $display("gave up waiting, %0d beats and %0d headers never came out",
                     exp_beats.size(), exp_hdrs.size());
            exp_beats.delete();
            exp_hdrs.delete();
        end
    endtask

    // one classic cycle; ack is taken as the end of the cycle
    task automatic wb_cycle(input logic we, input logic [3:0] adr, output logic [31:0] data);
        @(posedge switch_clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= $urandom(); // value is don't-care for a clear
        for (int t = 0; t < ACK_LIMIT; t++) begin
            @(posedge switch_clk);
            if (wb_ack) begin
                break;
            end
        end
        data = wb_dat_r;
        if (!wb_ack) begin
            timeouts++;
            $display("wishbone cycle to address %0d got no ack", adr);
        end
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic check_counts();
        logic [31:0] v;
        logic [3:0]  adr;
        for (int a = 0; a < 4; a++) begin
            wb_cycle(1'b0, 4'(a), v);
            check_stat(v, exp_cnt[a], a);
        end
        adr = 4'd4 + 4'($urandom() % 12); // unmapped
        wb_cycle(1'b0, adr, v);
        check_stat(v, 32'd0, int'(adr));
    endtask

    // kind 0 good, 1 bad fcs byte, 2 rx_er on a payload byte, 3 bad preamble or sfd
    task automatic run_frame(input int kind);
        logic [7:0]  body [$];
        logic [7:0]  line [$];
        logic [63:0] r;
        logic [31:0] rnd, fcs;
        mac_hdr_t    hdr;
        frame_beat_t b;
        int          len, n, idx, err_at;
        r = {$urandom(), $urandom()};
        hdr.dst = r[47:0];
        r = {$urandom(), $urandom()};
        hdr.src = r[47:0];
        for (int i = 5; i >= 0; i--) begin
            body.push_back(hdr.dst[8*i +: 8]); // first byte on the wire is the top octet
        end
        for (int i = 5; i >= 0; i--) begin
            body.push_back(hdr.src[8*i +: 8]);
        end
        rnd = $urandom();
        body.push_back(rnd[15:8]); // ethertype, not checked
        body.push_back(rnd[7:0]);
        len = 46 + int'($urandom() % 55);
        for (int i = 0; i < len; i++) begin
            rnd = $urandom();
            body.push_back(rnd[7:0]);
        end
        fcs = fcs_of(body);
        body.push_back(fcs[7:0]);
        body.push_back(fcs[15:8]);
        body.push_back(fcs[23:16]);
        body.push_back(fcs[31:24]);
        n = body.size();
        if (kind == 1) begin
            rnd = $urandom();
            idx = n - 1 - int'(rnd[9:8]);
            body[idx] = body[idx] ^ (8'h01 << rnd[2:0]); // single bit flip in the fcs
        end
        for (int i = 0; i < 7; i++) begin
            line.push_back(PREAMBLE_BYTE);
        end
        line.push_back(SFD_BYTE);
        foreach (body[i]) begin
            line.push_back(body[i]);
        end
        if (kind == 3) begin
            rnd = $urandom();
            line[rnd[10:8]] = line[rnd[10:8]] ^ (8'h01 << rnd[2:0]);
            exp_cnt[3] = exp_cnt[3] + 32'd1;
            exp_cnt[2] = exp_cnt[2] + 32'd1;
        end else begin
            for (int i = 0; i < n; i++) begin
                b.data  = body[i];
                b.sof   = (i == 0);
                b.eof   = (i == n - 1);
                b.error = (i == n - 1) && (kind != 0);
                exp_beats.push_back(b);
            end
            exp_hdrs.push_back(hdr);
            exp_cnt[0] = exp_cnt[0] + 32'd1;
            exp_cnt[1] = exp_cnt[1] + ((kind == 1) ? 32'd1 : 32'd0);
            exp_cnt[2] = exp_cnt[2] + ((kind != 0) ? 32'd1 : 32'd0);
        end
        err_at = (kind == 2) ? 22 + int'($urandom() % len) : -1; // payload starts at 22
        foreach (line[i]) begin
            @(posedge gmii_rx_clk);
            gmii_rx_dv   <= 1'b1;
            gmii_rx_data <= line[i];
            gmii_rx_er   <= (i == err_at);
        end
        @(posedge gmii_rx_clk);
        gmii_rx_dv   <= 1'b0;
        gmii_rx_er   <= 1'b0;
        gmii_rx_data <= 8'h00;
        repeat (11 + int'($urandom() % 8)) @(posedge gmii_rx_clk); // 12 idle or more
        wait_drained();
    endtask

    task automatic run_batch();
        for (int i = 0; i < BATCH; i++) begin
            run_frame((i < 4) ? i : int'($urandom() % 4)); // every kind at least once
        end
    endtask

    initial begin
        logic [31:0] v;
        void'($urandom(32'h7381));
        gmii_rx_data = 8'h00;
        gmii_rx_dv   = 1'b0;
        gmii_rx_er   = 1'b0;
        wb_cyc       = 1'b0;
        wb_stb       = 1'b0;
        wb_we        = 1'b0;
        wb_adr       = 4'd0;
        wb_dat_w     = 32'd0;
        for (int a = 0; a < 4; a++) begin
            exp_cnt[a] = 32'd0;
        end
        for (int t = 0; t < 20 && !switch_rst_n; t++) begin
            @(posedge switch_clk);
        end
        if (!switch_rst_n) begin
            timeouts++;
            $display("switch_rst_n was never released");
        end
        repeat (4) @(posedge gmii_rx_clk); // write side reset synchronizer
        run_batch();
        check_counts();
        wb_cycle(1'b1, 4'($urandom() % 16), v); // any write clears
        for (int a = 0; a < 4; a++) begin
            exp_cnt[a] = 32'd0;
        end
        check_counts();
        run_batch();
        check_counts();
        $display("beat errors %0d, header errors %0d, stat errors %0d, timeouts %0d",
                 beat_errs, hdr_errs, stat_errs, timeouts);
        if (beat_errs + hdr_errs + stat_errs + timeouts == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* build.f */
hdl/rx_tx_pkg.sv
hdl/cdc_byte_fifo.sv
hdl/rx_frame_fsm.sv
hdl/frame_byte_counter.sv
hdl/mac_header_capture.sv
hdl/rx_stats_regs.sv
hdl/rx_mac_control.sv
dv/tb_clk_gen.sv
dv/rx_mac_control_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds and runs the rx port testbench with Verilator, then scans the log
set -e
set -o pipefail

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
    --top-module rx_mac_control_tb \
    -f build.f \
    -o rx_mac_control_sim

./obj_dir/rx_mac_control_sim | tee sim.log

if grep -q "Testbench failed" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi
echo "simulation finished without a failure"
